//--- rtl/acq_defs.svh
// ==============================
// Acquisition front end widths
// Sample, channel, gain shift and
// averaging depth for the design
// ==============================
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// Signed ADC sample width
`define SAMPLE_WIDTH 16

// Channels in use and the width of the tag that selects them
`define CHANNEL_COUNT 2
`define CHANNEL_WIDTH 1

// Gain is a left shift of 0 to 7 places
`define SHIFT_WIDTH 3

// Four samples are averaged per output
`define AVG_LOG2 2

`endif

//--- rtl/acq_pkg.sv
// ==============================
// Acquisition front end types
// Vector types shared by the
// calibration and decimation path
// ==============================
`include "acq_defs.svh"

package acq_pkg;

    // One signed sample word
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Channel tag carried alongside every sample
    typedef logic [`CHANNEL_WIDTH-1:0] channel_t;

    // Gain expressed as a left shift amount
    typedef logic [`SHIFT_WIDTH-1:0] shift_t;

    // Holds the sum of a full averaging group without overflow
    typedef logic signed [`SAMPLE_WIDTH+`AVG_LOG2-1:0] accum_t;

    // Counts samples of one channel within its group
    typedef logic [`AVG_LOG2-1:0] count_t;

endpackage

//--- rtl/sample_stream_if.sv
// ==============================
// Tagged sample stream
// Valid/ready handshake carrying
// a sample and its channel tag
// ==============================
`timescale 1ns/1ps

interface sample_stream_if
    import acq_pkg::*;
();

    // Payload of one transfer
    sample_t  data;
    channel_t channel;

    // Transfer happens on a rising edge with both high
    logic     valid;
    logic     ready;

    // The source holds its payload and valid until the transfer
    modport source (
        output data,
        output channel,
        output valid,
        input  ready
    );

    // The sink only answers with ready
    modport sink (
        input  data,
        input  channel,
        input  valid,
        output ready
    );

endinterface

//--- rtl/saturating_adder.sv
// ==============================
// Saturating sample adder
// Signed add that clamps to the
// sample range on overflow
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module saturating_adder
    import acq_pkg::*;
(
    input  sample_t a,
    input  sample_t b,
    output sample_t sum
);

    // Extremes of the signed sample range
    localparam sample_t SAMPLE_MAX = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

    // One guard bit keeps the exact sum of two samples
    logic signed [`SAMPLE_WIDTH:0] wide_sum;

    assign wide_sum = {a[`SAMPLE_WIDTH-1], a} + {b[`SAMPLE_WIDTH-1], b};

    // The guard and sign bits differ only when the sum left the range
    // A clear guard bit then means the overflow went positive
    always_comb begin
        if (wide_sum[`SAMPLE_WIDTH] == wide_sum[`SAMPLE_WIDTH-1]) begin
            sum = wide_sum[`SAMPLE_WIDTH-1:0];
        end else if (!wide_sum[`SAMPLE_WIDTH]) begin
            sum = SAMPLE_MAX;
        end else begin
            sum = SAMPLE_MIN;
        end
    end

endmodule

//--- rtl/coefficient_bank.sv
// ==============================
// Calibration coefficient bank
// Per-channel offset and shift,
// read by the tag of the stream
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module coefficient_bank
    import acq_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     cfg_write,
    input  channel_t cfg_channel,
    input  logic     cfg_gain_select,
    input  sample_t  cfg_value,
    input  channel_t channel,
    output sample_t  offset,
    output shift_t   shift
);

    // One coefficient pair per channel
    sample_t offset_reg [`CHANNEL_COUNT];
    shift_t  shift_reg  [`CHANNEL_COUNT];

    // Coefficients come out of reset as an identity calibration
    // The gain select picks which register of the channel is written
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CHANNEL_COUNT; i++) begin
                offset_reg[i] <= '0;
                shift_reg[i]  <= '0;
            end
        end else if (cfg_write) begin
            if (cfg_gain_select) begin
                // Only the low bits of the value form the shift amount
                shift_reg[cfg_channel] <= cfg_value[`SHIFT_WIDTH-1:0];
            end else begin
                offset_reg[cfg_channel] <= cfg_value;
            end
        end
    end

    // Combinational read for the sample currently at the input
    assign offset = offset_reg[channel];
    assign shift  = shift_reg[channel];

endmodule

//--- rtl/calibration.sv
// ==============================
// Sample calibration stage
// Saturating offset then optional
// saturating gain shift, one
// registered stage on the stream
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module calibration
    import acq_pkg::*;
(
    input  logic    clock,
    input  logic    arst_n,
    input  logic    flush,
    input  logic    gain_enable,
    input  sample_t offset,
    input  shift_t  shift,
    sample_stream_if.sink   in_stream,
    sample_stream_if.source out_stream
);

    // Wide enough to hold a sample shifted by the largest amount
    localparam int WIDE_WIDTH = `SAMPLE_WIDTH + (1 << `SHIFT_WIDTH) - 1;

    localparam sample_t SAMPLE_MAX = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

    sample_t                      offset_sum;
    logic signed [WIDE_WIDTH-1:0] gain_wide;
    logic [WIDE_WIDTH-`SAMPLE_WIDTH:0] gain_upper;
    sample_t                      gain_sat;
    sample_t                      corrected;

    // Offset correction clamps before the gain is applied
    saturating_adder u_offset_adder (
        .a   (in_stream.data),
        .b   (offset),
        .sum (offset_sum)
    );

    // Exact shifted value, sign extended first so nothing is lost
    assign gain_wide  = WIDE_WIDTH'(offset_sum) <<< shift;

    // Sign bit of the sample and every bit above it
    assign gain_upper = gain_wide[WIDE_WIDTH-1:`SAMPLE_WIDTH-1];

    // The result fits when those bits all agree, otherwise clamp by sign
    always_comb begin
        if ((&gain_upper) || !(|gain_upper)) begin
            gain_sat = gain_wide[`SAMPLE_WIDTH-1:0];
        end else if (gain_wide[WIDE_WIDTH-1]) begin
            gain_sat = SAMPLE_MIN;
        end else begin
            gain_sat = SAMPLE_MAX;
        end
    end

    assign corrected = gain_enable ? gain_sat : offset_sum;

    // Accept when the stage is empty or its content leaves this cycle
    assign in_stream.ready = !out_stream.valid || out_stream.ready;

    // Valid follows the input whenever the stage can move
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_stream.valid <= 1'b0;
        end else if (flush) begin
            out_stream.valid <= 1'b0;
        end else if (in_stream.ready) begin
            out_stream.valid <= in_stream.valid;
        end
    end

    // Payload loads only on a transfer and holds under back-pressure
    always_ff @(posedge clock) begin
        if (in_stream.valid && in_stream.ready) begin
            out_stream.data    <= corrected;
            out_stream.channel <= in_stream.channel;
        end
    end

endmodule

//--- rtl/decimating_averager.sv
// ==============================
// Decimating averager
// Sums four samples per channel
// and emits their floor mean
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module decimating_averager
    import acq_pkg::*;
(
    input  logic clock,
    input  logic arst_n,
    input  logic flush,
    sample_stream_if.sink   in_stream,
    sample_stream_if.source out_stream
);

    // Partial sums and sample counts, kept apart per channel
    accum_t accum_reg [`CHANNEL_COUNT];
    count_t count_reg [`CHANNEL_COUNT];

    logic    accept;
    logic    group_done;
    accum_t  sum_value;
    sample_t mean_value;

    // A new sample is taken unless a mean is stuck at the output
    assign in_stream.ready = !out_stream.valid || out_stream.ready;
    assign accept          = in_stream.valid && in_stream.ready;

    // Running sum including the sample now at the input
    assign sum_value  = accum_reg[in_stream.channel] + accum_t'(in_stream.data);

    // The last sample of a group arrives when the count is all ones
    assign group_done = &count_reg[in_stream.channel];

    // Arithmetic shift divides by the group size, rounding down
    assign mean_value = sample_t'(sum_value >>> `AVG_LOG2);

    // Accumulator and counter update for the channel of the sample
    // A finished group restarts its accumulator at zero
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CHANNEL_COUNT; i++) begin
                accum_reg[i] <= '0;
                count_reg[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < `CHANNEL_COUNT; i++) begin
                accum_reg[i] <= '0;
                count_reg[i] <= '0;
            end
        end else if (accept) begin
            // Counter wraps to zero by itself after the last sample
            count_reg[in_stream.channel] <= count_reg[in_stream.channel] + 1'b1;
            accum_reg[in_stream.channel] <= group_done ? '0 : sum_value;
        end
    end

    // A new mean may replace one that is taken in the same cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_stream.valid <= 1'b0;
        end else if (flush) begin
            out_stream.valid <= 1'b0;
        end else if (accept && group_done) begin
            out_stream.valid <= 1'b1;
        end else if (out_stream.ready) begin
            out_stream.valid <= 1'b0;
        end
    end

    // Mean and its tag are captured with the last sample of the group
    always_ff @(posedge clock) begin
        if (accept && group_done) begin
            out_stream.data    <= mean_value;
            out_stream.channel <= in_stream.channel;
        end
    end

endmodule

//--- rtl/acquisition_frontend.sv
// ==============================
// Acquisition front end top
// Calibrates a tagged sample
// stream and averages it by four
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module acquisition_frontend
    import acq_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     gain_enable,
    input  logic     cfg_write,
    input  channel_t cfg_channel,
    input  logic     cfg_gain_select,
    input  sample_t  cfg_value,
    input  sample_t  in_data,
    input  channel_t in_channel,
    input  logic     in_valid,
    output logic     in_ready,
    output sample_t  out_data,
    output channel_t out_channel,
    output logic     out_valid,
    input  logic     out_ready
);

    // Coefficients for the channel at the calibration input
    sample_t cal_offset;
    shift_t  cal_shift;

    // Raw input, calibrated samples and averaged output
    sample_stream_if raw_stream ();
    sample_stream_if cal_stream ();
    sample_stream_if avg_stream ();

    // Input ports drive the raw stream as its source
    assign raw_stream.data    = in_data;
    assign raw_stream.channel = in_channel;
    assign raw_stream.valid   = in_valid;
    assign in_ready           = raw_stream.ready;

    coefficient_bank u_coefficient_bank (
        .clock           (clock),
        .arst_n          (arst_n),
        .cfg_write       (cfg_write),
        .cfg_channel     (cfg_channel),
        .cfg_gain_select (cfg_gain_select),
        .cfg_value       (cfg_value),
        .channel         (raw_stream.channel),
        .offset          (cal_offset),
        .shift           (cal_shift)
    );

    calibration u_calibration (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .gain_enable (gain_enable),
        .offset      (cal_offset),
        .shift       (cal_shift),
        .in_stream   (raw_stream.sink),
        .out_stream  (cal_stream.source)
    );

    decimating_averager u_decimating_averager (
        .clock      (clock),
        .arst_n     (arst_n),
        .flush      (flush),
        .in_stream  (cal_stream.sink),
        .out_stream (avg_stream.source)
    );

    // Averaged stream leaves through the output ports
    assign out_data         = avg_stream.data;
    assign out_channel      = avg_stream.channel;
    assign out_valid        = avg_stream.valid;
    assign avg_stream.ready = out_ready;

endmodule

//--- verif/tb_acquisition_frontend.sv
// ==============================
// Acquisition front end testbench
// Directed tests against a model
// of calibration and averaging
// ==============================
`timescale 1ns/1ps
`include "acq_defs.svh"

module tb_acquisition_frontend
    import acq_pkg::*;
();

    logic     clock, arst_n, flush, gain_enable, cfg_write, cfg_gain_select;
    channel_t cfg_channel, in_channel, out_channel;
    sample_t  cfg_value, in_data, out_data;
    logic     in_valid, in_ready, out_valid, out_ready;

    // Model coefficients and partial sums, kept per channel
    sample_t     offset_model [`CHANNEL_COUNT];
    int          shift_model  [`CHANNEL_COUNT];
    int          ref_sum      [`CHANNEL_COUNT];
    int          ref_count    [`CHANNEL_COUNT];

    // Completed means and their tags in the order the groups finished
    sample_t     expected_q [$];
    channel_t    expected_channel_q [$];
    sample_t     expected_mean;
    channel_t    expected_channel;
    logic [31:0] rng_state = 32'd57;
    logic        random_ready = 1'b0;
    int          cycles = 0;

    acquisition_frontend acquisition_frontend_inst (.*);

    always #5 clock = ~clock;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int clamp(int v);
        int hi;
        hi = (1 << (`SAMPLE_WIDTH - 1)) - 1;
        if (v > hi) return hi;
        if (v < -hi - 1) return -hi - 1;
        return v;
    endfunction

    // Offset with saturation, then an optional saturating multiply by 2^shift
    function automatic sample_t calibrate(sample_t d, channel_t ch);
        int v;
        v = clamp(int'(d) + int'(offset_model[ch]));
        if (gain_enable) v = clamp(v * (1 << shift_model[ch]));
        return sample_t'(v);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Every completed group of four must show up once and in completion order
    // The single output path keeps means in the order their last samples entered
    always @(negedge clock) begin
        if (arst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("Output on channel %0d arrived with no mean pending", out_channel);
                $display("Test FAILED");
                $fatal(1);
            end else begin
                expected_channel = expected_channel_q.pop_front();
                expected_mean = expected_q.pop_front();
                check_value("out_channel", expected_channel, out_channel);
                check_value("out_data", expected_mean, out_data);
            end
        end
    end

    // Output ready toggles randomly only while back-pressure is wanted
    always @(posedge clock) begin
        #1;
        out_ready = random_ready ? (next_rand() % 4 != 0) : 1'b1;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= 5000) begin
            $display("Timeout: the run did not finish within 5000 cycles");
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic write_coef(channel_t ch, logic gain_sel, sample_t value);
        cfg_write = 1'b1;
        cfg_channel = ch;
        cfg_gain_select = gain_sel;
        cfg_value = value;
        @(posedge clock);
        #1 cfg_write = 1'b0;
        if (gain_sel) shift_model[ch] = value[`SHIFT_WIDTH-1:0];
        else offset_model[ch] = value;
    endtask

    // Holds the sample until it is taken, then records it in the model
    task automatic send(channel_t ch, sample_t d);
        logic taken;
        in_valid = 1'b1;
        in_channel = ch;
        in_data = d;
        do begin
            @(negedge clock);
            taken = in_ready;
            @(posedge clock);
            #1;
        end while (!taken);
        in_valid = 1'b0;
        ref_sum[ch] += int'(calibrate(d, ch));
        ref_count[ch]++;
        // The fourth sample of a channel closes its group
        if (ref_count[ch] == (1 << `AVG_LOG2)) begin
            expected_q.push_back(sample_t'(ref_sum[ch] >>> `AVG_LOG2));
            expected_channel_q.push_back(ch);
            ref_sum[ch] = 0;
            ref_count[ch] = 0;
        end
    endtask

    task automatic drain();
        while (expected_q.size() != 0) @(posedge clock);
        #1;
    endtask

    task automatic reset_and_latency();
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
        send(0, 16'sd10);
        send(0, -16'sd3);
        send(0, 16'sd7);
        send(0, 16'sd1);
        // The mean sits in the averager one edge after calibration
        @(negedge clock);
        check_value("out_valid", 0, out_valid);
        @(negedge clock);
        check_value("out_valid", 1, out_valid);
        drain();
    endtask

    task automatic offset_saturation();
        write_coef(0, 0, 16'sh7000);
        write_coef(1, 0, -16'sh7000);
        send(0, 16'sh7fff);
        send(1, 16'sh8000);
        send(0, 16'sh1000);
        send(1, -16'sd1);
        send(0, 16'sh0100);
        send(1, 16'sh2000);
        send(0, -16'sd5);
        send(1, 16'sd3);
        drain();
    endtask

    // Same samples with the gain on and then off
    task automatic gain_clamping();
        write_coef(0, 0, 16'sh0010);
        write_coef(1, 0, -16'sh0020);
        write_coef(0, 1, 16'sd3);
        write_coef(1, 1, 16'sd7);
        for (int pass = 0; pass < 2; pass++) begin
            gain_enable = (pass == 0);
            send(0, 16'sh2000);
            send(1, -16'sh0400);
            send(0, -16'sh0123);
            send(1, 16'sd5);
            send(0, 16'sd77);
            send(1, -16'sh7f00);
            send(0, -16'sh4000);
            send(1, 16'sh00ff);
            drain();
        end
    endtask

    task automatic backpressure_run();
        gain_enable = 1'b1;
        write_coef(0, 0, 16'sh0123);
        write_coef(1, 0, -16'sh0200);
        write_coef(0, 1, 16'sd1);
        write_coef(1, 1, 16'sd2);
        random_ready = 1'b1;
        for (int i = 0; i < 96; i++) send(channel_t'(next_rand() % 2), sample_t'(next_rand()));
        // Close any group left open by the random channel choice
        for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
            while (ref_count[ch] != 0) send(channel_t'(ch), sample_t'(next_rand()));
        end
        random_ready = 1'b0;
        drain();
    endtask

    // Two samples are discarded by flush and must not reach the next mean
    task automatic flush_recovery();
        write_coef(0, 0, 16'sh0100);
        send(0, 16'sh4000);
        send(0, 16'sh4000);
        flush = 1'b1;
        @(posedge clock);
        #1 flush = 1'b0;
        ref_sum[0] = 0;
        ref_count[0] = 0;
        for (int i = 0; i < 4; i++) send(0, sample_t'(i * 9 - 20));
        drain();
    endtask

    initial begin
        clock = 0;
        arst_n = 0;
        flush = 0;
        gain_enable = 0;
        cfg_write = 0;
        cfg_channel = 0;
        cfg_gain_select = 0;
        cfg_value = 0;
        in_data = 0;
        in_channel = 0;
        in_valid = 0;
        out_ready = 1;
        for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
            offset_model[ch] = 0;
            shift_model[ch] = 0;
            ref_sum[ch] = 0;
            ref_count[ch] = 0;
        end
        repeat (4) @(posedge clock);
        #1 arst_n = 1;
        reset_and_latency();
        offset_saturation();
        gain_clamping();
        backpressure_run();
        flush_recovery();
        // A stray or repeated mean would appear in the idle cycles after the last group
        repeat (3) @(negedge clock);
        check_value("out_valid", 0, out_valid);
        $display("Test OK");
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/acq_pkg.sv
rtl/sample_stream_if.sv
rtl/saturating_adder.sv
rtl/coefficient_bank.sv
rtl/calibration.sv
rtl/decimating_averager.sv
rtl/acquisition_frontend.sv
verif/tb_acquisition_frontend.sv

//--- Makefile
TOP = tb_acquisition_frontend

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir
